// File: source/lcdPkg.sv
package lcdPkg;

  localparam int Columns = 64;  // Per chip half
  localparam int Pages = 8;
  localparam int ExprWidth = 12;  // Three glyph codes
  localparam int GlyphCols = 8;
  localparam int PosWidth = 9;
  localparam int UpperStart = 48;
  localparam int LowerStart = 64;
  localparam int WrapCol = 64;  // Lead at or past this refills
  localparam int Lanes = 3;

  typedef enum logic [7:0] {
    opDisplayOn = 8'h3F,
    opSetColumn = 8'h40,
    opStartLine = 8'hC0,
    opSetPage   = 8'hB8  // Page number in the low bits
  } lcdOpcode;

  typedef enum logic [2:0] {
    sInitOn,
    sInitColumn,
    sInitLine,
    sSetPage,
    sWriteColumn,
    sFrameGap
  } seqState;

  // 0-9 digits, 10-13 + - x /, 14-15 blank
  typedef logic [3:0] glyphCode;

  localparam logic [7:0] HeartUpper [GlyphCols] = '{
    8'hC0, 8'hE0, 8'hF0, 8'hE0, 8'hE0, 8'hF0, 8'hE0, 8'hC0
  };
  localparam logic [7:0] HeartLower [GlyphCols] = '{
    8'h01, 8'h03, 8'h07, 8'h0F, 8'h0F, 8'h07, 8'h03, 8'h01
  };

  function automatic logic [3:0] levelOf(input logic [6:0] score);
    logic [4:0] level;
    level = 5'(score / 7'd5) + 5'd1;
    if (level > 5'd9)
      level = 5'd9;  // Single digit on screen
    return level[3:0];
  endfunction

endpackage

// File: source/glyphRom.sv
`timescale 1ns/1ps

module glyphRom (
  input  lcdPkg::glyphCode glyph,
  input  logic [2:0]       glyphCol,
  input  logic             lowerHalf,
  output logic [7:0]       pattern
);
  import lcdPkg::*;

  localparam int Entries = 16 * GlyphCols;

  logic [15:0] fontTable [Entries];
  logic [15:0] word;

  // One line per glyph, upper page byte in the high half
  initial
  begin
    $readmemh("font.hex", fontTable);
  end

  assign word = fontTable[{glyph, glyphCol}];
  assign pattern = lowerHalf ? word[7:0] : word[15:8];

endmodule

// File: source/exprLane.sv
`timescale 1ns/1ps

module exprLane #(
  parameter int LaneIndex = 0
) (
  input  logic                         CLK,
  input  logic                         RESET,
  input  logic [6:0]                   column,
  input  logic [2:0]                   page,
  input  logic                         step,
  input  logic                         shift,
  input  logic [lcdPkg::ExprWidth-1:0] leadExpr,
  input  logic [lcdPkg::ExprWidth-1:0] trailExpr,
  output logic                         hit,
  output lcdPkg::glyphCode             glyph,
  output logic [2:0]                   glyphCol,
  output logic                         atEdge
);
  import lcdPkg::*;

  localparam int Span = 3 * GlyphCols;
  localparam int MaxPos = 127 + GlyphCols;
  localparam glyphCode FirstBlank = 4'd14;

  logic [PosWidth-1:0] leadPos;
  logic [PosWidth-1:0] trailPos;
  logic [PosWidth-1:0] colPos;
  logic [PosWidth-1:0] leadOff;
  logic [PosWidth-1:0] trailOff;
  logic [PosWidth-1:0] offset;
  logic inLead;
  logic inTrail;
  logic owned;

  function automatic glyphCode nibbleAt(input logic [ExprWidth-1:0] expr,
                                        input logic [1:0] slot);
    case (slot)
      2'd0: return expr[11:8];  // Leftmost glyph
      2'd1: return expr[7:4];
      default: return expr[3:0];
    endcase
  endfunction

  assign colPos = PosWidth'(column);
  assign leadOff = colPos - leadPos;
  assign trailOff = colPos - trailPos;
  assign inLead = (colPos >= leadPos) && (leadOff < PosWidth'(Span));
  assign inTrail = (colPos >= trailPos) && (trailOff < PosWidth'(Span));
  assign owned = (page[2:1] == 2'(LaneIndex + 1));  // Two pages per lane

  assign offset = inLead ? leadOff : trailOff;
  assign glyph = inLead ? nibbleAt(leadExpr, offset[4:3]) : nibbleAt(trailExpr, offset[4:3]);
  assign glyphCol = offset[2:0];
  assign hit = owned && (inLead || inTrail) && (glyph < FirstBlank);
  assign atEdge = (leadPos >= PosWidth'(WrapCol));

  always_ff @(posedge CLK or negedge RESET)
  begin
    if (!RESET)
    begin
      leadPos <= PosWidth'(UpperStart);
      trailPos <= PosWidth'(LowerStart);
    end
    else if (shift)
    begin
      trailPos <= leadPos;  // Lead becomes the trailing expression
      leadPos <= '0;
    end
    else if (step)
    begin
      leadPos <= leadPos + 1'b1;
      trailPos <= trailPos + 1'b1;
    end
  end

  // Holds only while the sequencer refills at WrapCol
  posBound: assert property (@(posedge CLK) disable iff (!RESET)
    (leadPos <= PosWidth'(MaxPos)) && (trailPos <= PosWidth'(MaxPos)));

endmodule

// File: source/frameSequencer.sv
`timescale 1ns/1ps

module frameSequencer #(
  parameter int ClkDivBits = 7,
  parameter int FrameGapTicks = 256
) (
  input  logic                     CLK,
  input  logic                     RESET,
  input  logic [6:0]               score,
  input  logic [lcdPkg::Lanes-1:0] atEdge,
  output logic [6:0]               column,
  output logic [2:0]               page,
  output logic                     step,
  output logic                     shift,
  output logic                     update,
  output lcdPkg::lcdOpcode         cmdByte,
  output logic                     dataMode,
  output logic                     load,
  output logic                     LCD_ENABLE,
  output logic                     LCD_CS1,
  output logic                     LCD_CS2,
  output logic                     LCD_RST
);
  import lcdPkg::*;

  localparam int GapBits = $clog2(FrameGapTicks + 1);
  localparam int TickCycles = 2 ** ClkDivBits;
  localparam logic [6:0] ClearCol = 7'd32;  // Renders blank on all pages before any step

  seqState state;
  logic [ClkDivBits-1:0] divCount;
  logic [1:0] phase;
  logic [6:0] colCount;
  logic [GapBits-1:0] gapCount;
  logic [2:0] frameCount;
  logic [2:0] nextFrame;
  logic [3:0] level;
  logic [1:0] rateBit;
  logic clearing;
  logic stepDone;
  logic tick;
  logic writeDone;
  logic lastCol;
  logic gapStart;

  assign tick = &divCount;
  assign writeDone = tick && (phase == 2'd2);
  assign lastCol = clearing ? (colCount == 7'(Columns - 1)) : (colCount == 7'(2 * Columns - 1));
  assign gapStart = writeDone && (state == sWriteColumn) && lastCol && !clearing
                    && (page == 3'(Pages - 1));

  assign level = levelOf(score);
  assign rateBit = (level >= 4'd4) ? 2'd0 : ((level == 4'd3) ? 2'd1 : 2'd2);
  assign nextFrame = frameCount + 3'd1;
  assign step = gapStart && nextFrame[rateBit];
  assign shift = stepDone && (|atEdge);  // Lanes have stepped by now
  assign update = shift;

  assign load = tick && (phase == 2'd0) && (state != sFrameGap);
  assign dataMode = (state == sWriteColumn);
  assign column = clearing ? ClearCol : colCount;

  always_comb
  begin
    case (state)
      sInitOn: cmdByte = opDisplayOn;
      sInitColumn: cmdByte = opSetColumn;
      sInitLine: cmdByte = opStartLine;
      default: cmdByte = opSetPage;
    endcase
  end

  always_ff @(posedge CLK or negedge RESET)
  begin
    if (!RESET)
    begin
      divCount <= '0;
      stepDone <= 1'b0;
    end
    else
    begin
      divCount <= divCount + 1'b1;
      stepDone <= step;
    end
  end

  // Each write: settle, enable high, enable low
  always_ff @(posedge CLK or negedge RESET)
  begin
    if (!RESET)
    begin
      state <= sInitOn;
      phase <= 2'd0;
      page <= 3'd0;
      colCount <= 7'd0;
      gapCount <= '0;
      frameCount <= 3'd0;
      clearing <= 1'b1;
      LCD_ENABLE <= 1'b0;
      LCD_CS1 <= 1'b1;
      LCD_CS2 <= 1'b1;
      LCD_RST <= 1'b0;
    end
    else if (tick)
    begin
      case (phase)
        2'd0:
        begin
          if (state == sFrameGap)
          begin
            if (gapCount == GapBits'(FrameGapTicks - 1))
            begin
              gapCount <= '0;
              state <= sSetPage;
            end
            else
              gapCount <= gapCount + 1'b1;
          end
          else
          begin
            phase <= 2'd1;
            LCD_RST <= 1'b1;
            if (dataMode && !clearing)
            begin
              LCD_CS1 <= (colCount < 7'(Columns));  // Left half
              LCD_CS2 <= (colCount >= 7'(Columns));
            end
            else
            begin
              LCD_CS1 <= 1'b1;
              LCD_CS2 <= 1'b1;
            end
          end
        end
        2'd1:
        begin
          LCD_ENABLE <= 1'b1;
          phase <= 2'd2;
        end
        default:
        begin
          LCD_ENABLE <= 1'b0;
          phase <= 2'd0;
          case (state)
            sInitOn: state <= sInitColumn;
            sInitColumn: state <= sInitLine;
            sInitLine: state <= sSetPage;
            sSetPage: state <= sWriteColumn;
            sWriteColumn:
            begin
              if (!lastCol)
                colCount <= colCount + 7'd1;
              else
              begin
                colCount <= 7'd0;
                page <= page + 3'd1;  // Wraps to 0 after the last page
                if (page != 3'(Pages - 1))
                  state <= sSetPage;
                else if (clearing)
                begin
                  clearing <= 1'b0;
                  state <= sSetPage;
                end
                else
                begin
                  state <= sFrameGap;
                  frameCount <= nextFrame[rateBit] ? 3'd0 : nextFrame;
                end
              end
            end
            default: state <= state;
          endcase
        end
      endcase
    end
  end

  enableOneTick: assert property (@(posedge CLK) disable iff (!RESET)
    (tick && LCD_ENABLE) |-> !$past(LCD_ENABLE, TickCycles));

  // Refill only right after the step that brought a lead to the edge
  shiftAfterStep: assert property (@(posedge CLK) disable iff (!RESET)
    shift |-> $past(step && !(|atEdge)));

endmodule

// File: source/pixelComposer.sv
`timescale 1ns/1ps

module pixelComposer (
  input  logic                                 CLK,
  input  logic                                 RESET,
  input  lcdPkg::lcdOpcode                     cmdByte,
  input  logic                                 dataMode,
  input  logic                                 load,
  input  logic [2:0]                           page,
  input  logic [6:0]                           column,
  input  logic [6:0]                           score,
  input  logic [2:0]                           Life,
  input  logic [lcdPkg::Lanes-1:0]             laneHit,
  input  lcdPkg::glyphCode [lcdPkg::Lanes-1:0] laneGlyph,
  input  logic [lcdPkg::Lanes-1:0][2:0]        laneGlyphCol,
  output logic [7:0]                           LCD_DATA,
  output logic                                 LCD_DI,
  output logic                                 LCD_RW
);
  import lcdPkg::*;

  localparam logic [7:0] DigitCol = 8'd24;
  localparam logic [7:0] HeartCol = 8'd80;

  logic statusRow;
  logic [7:0] colWide;
  logic inDigit;
  logic inHeart;
  logic [7:0] heartByte;
  logic selHit;
  glyphCode selGlyph;
  logic [2:0] selCol;
  glyphCode romGlyph;
  logic [2:0] romCol;
  logic [7:0] romByte;
  logic [7:0] pixelByte;
  logic [7:0] cmdFull;

  assign statusRow = (page < 3'd2);
  assign colWide = {1'b0, column};
  assign inDigit = (colWide >= DigitCol) && (colWide < DigitCol + 8'(GlyphCols));
  assign inHeart = (colWide >= HeartCol) && (colWide < HeartCol + {2'b00, Life, 3'b000});
  assign heartByte = page[0] ? HeartLower[column[2:0]] : HeartUpper[column[2:0]];

  // Owning lane of the current page
  always_comb
  begin
    selHit = 1'b0;
    selGlyph = laneGlyph[0];
    selCol = laneGlyphCol[0];
    for (int k = 0; k < Lanes; k++)
    begin
      if (page[2:1] == 2'(k + 1))
      begin
        selHit = laneHit[k];
        selGlyph = laneGlyph[k];
        selCol = laneGlyphCol[k];
      end
    end
  end

  assign romGlyph = statusRow ? levelOf(score) : selGlyph;
  assign romCol = statusRow ? column[2:0] : selCol;  // Status items start on 8-column borders

  glyphRom i_glyphRom (
    .glyph(romGlyph),
    .glyphCol(romCol),
    .lowerHalf(page[0]),
    .pattern(romByte)
  );

  always_comb
  begin
    if (statusRow)
      pixelByte = inDigit ? romByte : (inHeart ? heartByte : 8'h00);
    else
      pixelByte = selHit ? romByte : 8'h00;
  end

  assign cmdFull = (cmdByte == opSetPage) ? (cmdByte | {5'b00000, page}) : cmdByte;
  assign LCD_RW = 1'b0;  // Write-only panel

  always_ff @(posedge CLK or negedge RESET)
  begin
    if (!RESET)
    begin
      LCD_DATA <= 8'h00;
      LCD_DI <= 1'b0;
    end
    else if (load)
    begin
      LCD_DATA <= dataMode ? pixelByte : cmdFull;
      LCD_DI <= dataMode;
    end
  end

endmodule

// File: source/lcdTop.sv
`timescale 1ns/1ps

module lcdTop #(
  parameter int ClkDivBits = 7,
  parameter int FrameGapTicks = 256
) (
  input  logic                         CLK,
  input  logic                         RESET,
  input  logic [lcdPkg::ExprWidth-1:0] exp1,
  input  logic [lcdPkg::ExprWidth-1:0] exp2,
  input  logic [lcdPkg::ExprWidth-1:0] exp3,
  input  logic [lcdPkg::ExprWidth-1:0] exp4,
  input  logic [lcdPkg::ExprWidth-1:0] exp5,
  input  logic [lcdPkg::ExprWidth-1:0] exp6,
  input  logic [6:0]                   score,
  input  logic [2:0]                   Life,
  output logic                         LCD_ENABLE,
  output logic                         LCD_RW,
  output logic                         LCD_DI,
  output logic                         LCD_CS1,
  output logic                         LCD_CS2,
  output logic                         LCD_RST,
  output logic [7:0]                   LCD_DATA,
  output logic                         update
);
  import lcdPkg::*;

  logic [6:0] column;
  logic [2:0] page;
  logic step;
  logic shift;
  lcdOpcode cmdByte;
  logic dataMode;
  logic load;
  logic [Lanes-1:0] atEdge;
  logic [Lanes-1:0] laneHit;
  glyphCode [Lanes-1:0] laneGlyph;
  logic [Lanes-1:0][2:0] laneGlyphCol;
  wire [Lanes-1:0][ExprWidth-1:0] leadExpr = {exp3, exp2, exp1};
  wire [Lanes-1:0][ExprWidth-1:0] trailExpr = {exp6, exp5, exp4};

  frameSequencer #(
    .ClkDivBits(ClkDivBits),
    .FrameGapTicks(FrameGapTicks)
  ) i_frameSequencer (
    .CLK(CLK),
    .RESET(RESET),
    .score(score),
    .atEdge(atEdge),
    .column(column),
    .page(page),
    .step(step),
    .shift(shift),
    .update(update),
    .cmdByte(cmdByte),
    .dataMode(dataMode),
    .load(load),
    .LCD_ENABLE(LCD_ENABLE),
    .LCD_CS1(LCD_CS1),
    .LCD_CS2(LCD_CS2),
    .LCD_RST(LCD_RST)
  );

  for (genvar k = 0; k < Lanes; k++)
  begin : g_lane
    exprLane #(
      .LaneIndex(k)
    ) i_exprLane (
      .CLK(CLK),
      .RESET(RESET),
      .column(column),
      .page(page),
      .step(step),
      .shift(shift),
      .leadExpr(leadExpr[k]),
      .trailExpr(trailExpr[k]),
      .hit(laneHit[k]),
      .glyph(laneGlyph[k]),
      .glyphCol(laneGlyphCol[k]),
      .atEdge(atEdge[k])
    );
  end

  pixelComposer i_pixelComposer (
    .CLK(CLK),
    .RESET(RESET),
    .cmdByte(cmdByte),
    .dataMode(dataMode),
    .load(load),
    .page(page),
    .column(column),
    .score(score),
    .Life(Life),
    .laneHit(laneHit),
    .laneGlyph(laneGlyph),
    .laneGlyphCol(laneGlyphCol),
    .LCD_DATA(LCD_DATA),
    .LCD_DI(LCD_DI),
    .LCD_RW(LCD_RW)
  );

endmodule

// File: sim/lcdMonitor.sv
`timescale 1ns/1ps

module lcdMonitor #(
  parameter int ClkDivBits = 2
) (
  input  logic        CLK,
  input  logic        RESET,
  input  logic        LCD_ENABLE,
  input  logic        LCD_RW,
  input  logic        LCD_DI,
  input  logic        LCD_CS1,
  input  logic        LCD_CS2,
  input  logic        LCD_RST,
  input  logic [7:0]  LCD_DATA,
  input  logic        update,
  input  logic [2:0]  Life,
  input  logic [3:0]  level,
  input  logic [11:0] exp1,
  input  logic [11:0] exp2,
  input  logic [11:0] exp3,
  input  logic [11:0] exp4,
  input  logic [11:0] exp5,
  input  logic [11:0] exp6,
  output int          framesDone,
  output int          byteChecks,
  output int          valueErrors,
  output int          otherErrors
);
  import lcdPkg::*;

  localparam int PulseCycles = 2 ** ClkDivBits;
  localparam int ClearWrites = Pages * Columns;

  logic [15:0] font [16 * GlyphCols];
  int writes;
  int clearCount;
  int curPage;
  int curCol;
  int nextPage;
  int leadPos;  // All lanes move together
  int trailPos;
  int expectUpdates;
  int seenUpdates;
  int highCycles;
  logic [2:0] frameCount;
  logic lastEnable;
  logic [7:0] lastData;
  logic lastDi;
  logic lastCs1;
  logic lastCs2;

  initial
  begin
    $readmemh("font.hex", font);
  end

  task automatic compareValue(input string name, input int got, input int want);
    if (got != want)
    begin
      valueErrors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  task automatic otherError(input string what);
    otherErrors++;
    $display("At %0t ns: %s", $time, what);
  endtask

  function automatic logic [7:0] fontByte(input int code, input int col, input int p);
    logic [15:0] word;
    word = font[code * GlyphCols + col];
    return (p % 2 == 1) ? word[7:0] : word[15:8];
  endfunction

  function automatic logic [11:0] laneExpr(input int k, input bit trail);
    case (k)
      0: return trail ? exp4 : exp1;
      1: return trail ? exp5 : exp2;
      default: return trail ? exp6 : exp3;
    endcase
  endfunction

  function automatic logic [7:0] expectedByte(input int p, input int c);
    int k;
    int off;
    logic [11:0] expr;
    logic [3:0] code;
    if (p < 2)
    begin
      if (c >= 24 && c < 32)
        return fontByte(level, c - 24, p);
      if (c >= 80 && c < 80 + 8 * Life)
        return (p % 2 == 1) ? HeartLower[(c - 80) % 8] : HeartUpper[(c - 80) % 8];
      return 8'h00;
    end
    k = (p - 2) / 2;  // Two pages per lane
    if (c >= leadPos && c < leadPos + 24)
    begin
      off = c - leadPos;
      expr = laneExpr(k, 1'b0);
    end
    else if (c >= trailPos && c < trailPos + 24)
    begin
      off = c - trailPos;
      expr = laneExpr(k, 1'b1);
    end
    else
      return 8'h00;
    code = expr[11 - 4 * (off / 8) -: 4];  // Leftmost glyph in the top nibble
    if (code >= 4'd14)
      return 8'h00;
    return fontByte(code, off % 8, p);
  endfunction

  task automatic checkResetState();
    compareValue("LCD_ENABLE", LCD_ENABLE, 0);
    compareValue("LCD_RW", LCD_RW, 0);
    compareValue("LCD_DI", LCD_DI, 0);
    compareValue("LCD_RST", LCD_RST, 0);
    compareValue("LCD_DATA", LCD_DATA, 0);
    compareValue("LCD_CS1", LCD_CS1, 1);
    compareValue("LCD_CS2", LCD_CS2, 1);
    compareValue("update", update, 0);
  endtask

  task automatic checkBusTiming();
    compareValue("LCD_RW", LCD_RW, 0);
    if (LCD_ENABLE)
      highCycles++;
    if (lastEnable && LCD_ENABLE && (LCD_DATA !== lastData || LCD_DI !== lastDi
        || LCD_CS1 !== lastCs1 || LCD_CS2 !== lastCs2))
      otherError("bus lines changed while LCD_ENABLE was high");
    if (lastEnable && !LCD_ENABLE)
    begin
      compareValue("LCD_ENABLE high cycles", highCycles, PulseCycles);
      highCycles = 0;
    end
  endtask

  task automatic endFrame();
    int bitSel;
    logic [2:0] nextCount;
    framesDone++;
    bitSel = (level >= 4'd4) ? 0 : ((level == 4'd3) ? 1 : 2);
    nextCount = frameCount + 3'd1;
    if (nextCount[bitSel])
    begin
      frameCount = 3'd0;  // Scroll one column
      leadPos++;
      trailPos++;
      if (leadPos >= WrapCol)
      begin
        trailPos = leadPos;
        leadPos = 0;
        expectUpdates++;
      end
    end
    else
      frameCount = nextCount;
  endtask

  task automatic decodeWrite();
    compareValue("LCD_RST", LCD_RST, 1);
    if (writes < 3)
    begin
      compareValue("LCD_DI", LCD_DI, 0);
      compareValue("LCD_DATA", LCD_DATA, (writes == 0) ? 8'h3F : ((writes == 1) ? 8'h40 : 8'hC0));
    end
    else if (!LCD_DI)
    begin
      if (LCD_DATA[7:3] != 5'b10111)
        otherError("unexpected LCD command after init");
      else
      begin
        compareValue("update pulses", seenUpdates, expectUpdates);
        seenUpdates = 0;
        expectUpdates = 0;
        compareValue("LCD page", LCD_DATA[2:0], nextPage);
        curPage = LCD_DATA[2:0];
        nextPage = (curPage + 1) % Pages;
        curCol = 0;
      end
    end
    else if (clearCount < ClearWrites)
    begin
      compareValue($sformatf("LCD_DATA clear p%0d c%0d", curPage, curCol), LCD_DATA, 0);
      compareValue("LCD_CS1", LCD_CS1, 1);
      compareValue("LCD_CS2", LCD_CS2, 1);
      clearCount++;
      curCol++;
    end
    else if (curCol >= 2 * Columns)
      otherError("data write after the last column of a page");
    else
    begin
      compareValue("LCD_CS1", LCD_CS1, curCol < Columns);
      compareValue("LCD_CS2", LCD_CS2, curCol >= Columns);
      compareValue($sformatf("LCD_DATA p%0d c%0d", curPage, curCol), LCD_DATA,
                   expectedByte(curPage, curCol));
      byteChecks++;
      if (curPage == Pages - 1 && curCol == 2 * Columns - 1)
        endFrame();
      curCol++;
    end
    writes++;
  endtask

  // Write strobe seen falling at the next CLK low phase
  always @(negedge CLK)
  begin
    if (!RESET)
    begin
      checkResetState();
      writes = 0;
      clearCount = 0;
      curPage = 0;
      curCol = 0;
      nextPage = 0;
      leadPos = UpperStart;
      trailPos = LowerStart;
      frameCount = 3'd0;
      expectUpdates = 0;
      seenUpdates = 0;
      highCycles = 0;
    end
    else
    begin
      checkBusTiming();
      if (update)
        seenUpdates++;
      if (lastEnable && !LCD_ENABLE)
        decodeWrite();
    end
    lastEnable = LCD_ENABLE;
    lastData = LCD_DATA;
    lastDi = LCD_DI;
    lastCs1 = LCD_CS1;
    lastCs2 = LCD_CS2;
  end

endmodule

// File: sim/tbLcdTop.sv
`timescale 1ns/1ps

module tbLcdTop;
  import lcdPkg::*;

  localparam int ClkDivBits = 2;
  localparam int FrameGapTicks = 4;
  localparam int FrameCycles = (Pages * (2 * Columns + 1) * 3 + FrameGapTicks) * (2 ** ClkDivBits);
  localparam logic [31:0] Seed = 32'h28b923a4;
  localparam int Rows = 5;

  // One row per test, level is score / 5 + 1 capped at 9
  localparam int RowScore [Rows] = '{0, 12, 20, 99, 7};
  localparam int RowLife [Rows] = '{3, 0, 7, 5, 1};
  localparam int RowLevel [Rows] = '{1, 3, 5, 9, 2};
  localparam int RowFrames [Rows] = '{2, 3, 18, 4, 4};

  logic CLK;
  logic RESET;
  logic [11:0] exp1;
  logic [11:0] exp2;
  logic [11:0] exp3;
  logic [11:0] exp4;
  logic [11:0] exp5;
  logic [11:0] exp6;
  logic [6:0] score;
  logic [2:0] Life;
  logic [3:0] rowLevel;
  logic LCD_ENABLE;
  logic LCD_RW;
  logic LCD_DI;
  logic LCD_CS1;
  logic LCD_CS2;
  logic LCD_RST;
  logic [7:0] LCD_DATA;
  logic update;
  logic [11:0] rowExpr [Rows][6];
  logic [31:0] lfsr;
  int framesDone;
  int byteChecks;
  int valueErrors;
  int otherErrors;
  int totalFrames;
  int cycleLimit;
  int cycles;

  lcdTop #(
    .ClkDivBits(ClkDivBits),
    .FrameGapTicks(FrameGapTicks)
  ) i_lcdTop (
    .CLK(CLK),
    .RESET(RESET),
    .exp1(exp1),
    .exp2(exp2),
    .exp3(exp3),
    .exp4(exp4),
    .exp5(exp5),
    .exp6(exp6),
    .score(score),
    .Life(Life),
    .LCD_ENABLE(LCD_ENABLE),
    .LCD_RW(LCD_RW),
    .LCD_DI(LCD_DI),
    .LCD_CS1(LCD_CS1),
    .LCD_CS2(LCD_CS2),
    .LCD_RST(LCD_RST),
    .LCD_DATA(LCD_DATA),
    .update(update)
  );

  lcdMonitor #(
    .ClkDivBits(ClkDivBits)
  ) monitor (
    .CLK(CLK),
    .RESET(RESET),
    .LCD_ENABLE(LCD_ENABLE),
    .LCD_RW(LCD_RW),
    .LCD_DI(LCD_DI),
    .LCD_CS1(LCD_CS1),
    .LCD_CS2(LCD_CS2),
    .LCD_RST(LCD_RST),
    .LCD_DATA(LCD_DATA),
    .update(update),
    .Life(Life),
    .level(rowLevel),
    .exp1(exp1),
    .exp2(exp2),
    .exp3(exp3),
    .exp4(exp4),
    .exp5(exp5),
    .exp6(exp6),
    .framesDone(framesDone),
    .byteChecks(byteChecks),
    .valueErrors(valueErrors),
    .otherErrors(otherErrors)
  );

  always #2 CLK = ~CLK;

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [11:0] randomExpr();
    logic [11:0] value;
    value = '0;
    for (int i = 0; i < 12; i++)
    begin
      value = {value[10:0], lfsr[0]};
      lfsr = lfsrStep(lfsr);
    end
    return value;
  endfunction

  task automatic applyRow(input int r);
    score = 7'(RowScore[r]);
    Life = 3'(RowLife[r]);
    rowLevel = 4'(RowLevel[r]);
    exp1 = rowExpr[r][0];
    exp2 = rowExpr[r][1];
    exp3 = rowExpr[r][2];
    exp4 = rowExpr[r][3];
    exp5 = rowExpr[r][4];
    exp6 = rowExpr[r][5];
  endtask

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles > cycleLimit)
    begin
      $display("Run stopped after %0d cycles before the stimulus table was done", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial
  begin
    int target;
    target = 0;
    CLK = 1'b0;
    RESET = 1'b0;
    lfsr = Seed;
    totalFrames = 0;
    for (int r = 0; r < Rows; r++)
    begin
      for (int e = 0; e < 6; e++)
        rowExpr[r][e] = randomExpr();
      totalFrames += RowFrames[r];
    end
    cycleLimit = (totalFrames + 2) * FrameCycles;  // Init and clear fit in one frame
    applyRow(0);
    repeat (3) @(posedge CLK);
    #1 RESET = 1'b1;

    // New inputs only in the frame gap
    for (int r = 0; r < Rows; r++)
    begin
      target += RowFrames[r];
      wait (framesDone >= target);
      @(posedge CLK);
      #1;
      if (r + 1 < Rows)
        applyRow(r + 1);
    end

    @(negedge LCD_ENABLE);  // Next set-page write closes the last update check
    repeat (2) @(posedge CLK);

    $display("Frames %0d, bytes compared %0d, value errors %0d, other errors %0d",
             framesDone, byteChecks, valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: src.f
source/lcdPkg.sv
source/glyphRom.sv
source/exprLane.sv
source/frameSequencer.sv
source/pixelComposer.sv
source/lcdTop.sv
sim/lcdMonitor.sv
sim/tbLcdTop.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
LINTOPTS = --lint-only --timing -Wall
TOP      = tbLcdTop
FILELIST = src.f
OBJDIR   = obj_dir
LOG      = sim.log
FAILMSG  = TESTS FAILED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(SIM) $(LINTOPTS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: font.hex
// One glyph per line, codes 0 to 15, columns 0 to 7 left to right
// Each word holds the upper page byte high and the lower page byte low
0000 F00F F81F 0C30 0C30 F81F F00F 0000 // 0
0000 0000 1030 1830 FC3F FC3F 0030 0000 // 1
0000 1838 1C3C 0C36 0C33 FC31 F830 0000 // 2
0000 1818 1C38 8C31 8C31 FC3F 781E 0000 // 3
0000 8003 E003 7803 FC3F FC3F 0003 0000 // 4
0000 FC19 FC39 CC30 CC30 CC3F 8C1F 0000 // 5
0000 F01F F83F CC30 CC30 CC3F 881F 0000 // 6
0000 0C00 0C38 0C3E 8C07 FC01 7C00 0000 // 7
0000 781E FC3F 8C31 8C31 FC3F 781E 0000 // 8
0000 F811 FC33 0C33 0C33 FC1F F80F 0000 // 9
0000 8001 8001 F00F F00F 8001 8001 0000 // +
0000 8001 8001 8001 8001 8001 8001 0000 // -
0000 300C 6006 C003 C003 6006 300C 0000 // x
0000 8001 8001 B00D B00D 8001 8001 0000 // /
0000 0000 0000 0000 0000 0000 0000 0000 // blank
0000 0000 0000 0000 0000 0000 0000 0000 // blank
